// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := vec_ctrl_tb
RTL_TOP    := vec_ctrl_top
FILELIST   := vec_ctrl.f
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi
	@grep -q "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		logic/vec_cfg_pkg.sv logic/vec_isa_pkg.sv logic/dec_op_if.sv logic/wb_if.sv \
		logic/vec_decode.sv logic/vec_execute.sv logic/vec_result.sv logic/vec_ctrl_top.sv

clean:
	rm -rf obj_dir $(LOG)

// File: logic/dec_op_if.sv
`timescale 1ns/10ps

interface dec_op_if
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;
();

  // Buffered operation
  logic      valid;
  logic      illegal;
  opcode_e   opcode;
  vsew_e     vsew;
  vlmul_e    vlmul;
  reg_idx_t  vd;
  reg_idx_t  vs1;
  csr_addr_t csr_addr;
  elen_t     rs1;
  reg_idx_t  rd;

  // Operation leaves the buffer
  logic      pop;

  modport decode (
    output valid, illegal, opcode, vsew, vlmul, vd, vs1, csr_addr, rs1, rd,
    input  pop
  );

  modport execute (
    input  valid, illegal, opcode, vsew, vlmul, vd, vs1, csr_addr, rs1, rd,
    output pop
  );

endinterface

// File: logic/vec_cfg_pkg.sv
package vec_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Machine sizes
  //////////////////////////////////////////////////////////////////////

  // Vector register length in bits and bytes
  localparam int unsigned VLEN  = 256;
  localparam int unsigned VLENB = VLEN / 8;

  // Element and scalar data width
  localparam int unsigned ELEN = 32;

  // Instructions in flight at the execution unit
  localparam int unsigned NR_INSN = 4;

  // Derived widths
  localparam int unsigned ID_W       = $clog2(NR_INSN);
  localparam int unsigned VL_W       = $clog2(VLENB * 8) + 1;
  localparam int unsigned REG_W      = 5;
  localparam int unsigned CSR_ADDR_W = 12;

  typedef logic [ELEN-1:0]       elen_t;
  typedef logic [VL_W-1:0]       vlen_t;
  typedef logic [ID_W-1:0]       insn_id_t;
  typedef logic [REG_W-1:0]      reg_idx_t;
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  //////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////

  localparam csr_addr_t CSR_VSTART = 12'h008;
  localparam csr_addr_t CSR_VL     = 12'hC20;
  localparam csr_addr_t CSR_VTYPE  = 12'hC21;
  localparam csr_addr_t CSR_VLENB  = 12'hC22;

endpackage

// File: logic/vec_ctrl_top.sv
`timescale 1ns/10ps

module vec_ctrl_top
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Core issue
  input  logic     issue_valid_i,
  output logic     issue_ready_o,
  input  elen_t    issue_instr_i,
  input  elen_t    issue_rs1_i,
  input  reg_idx_t issue_rd_i,
  output logic     issue_resp_valid_o,
  output logic     issue_accept_o,
  output logic     busy_o,
  // Execution unit
  output logic     unit_req_valid_o,
  input  logic     unit_req_ready_i,
  output opcode_e  unit_req_op_o,
  output reg_idx_t unit_req_vd_o,
  output reg_idx_t unit_req_vs1_o,
  output vsew_e    unit_req_vsew_o,
  output vlmul_e   unit_req_vlmul_o,
  output vlen_t    unit_req_vl_o,
  output vlen_t    unit_req_vstart_o,
  output insn_id_t unit_req_id_o,
  input  logic     unit_rsp_valid_i,
  input  insn_id_t unit_rsp_id_i,
  // Core write-back
  output logic     result_valid_o,
  input  logic     result_ready_i,
  output reg_idx_t result_rd_o,
  output elen_t    result_data_o
);

  dec_op_if dec_op ();
  wb_if     wb ();

  vec_decode vec_decode_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_instr_i (issue_instr_i),
    .issue_rs1_i   (issue_rs1_i),
    .issue_rd_i    (issue_rd_i),
    .op            (dec_op.decode)
  );

  vec_execute vec_execute_inst (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .op                 (dec_op.execute),
    .wb                 (wb.execute),
    .issue_resp_valid_o (issue_resp_valid_o),
    .issue_accept_o     (issue_accept_o),
    .busy_o             (busy_o),
    .unit_req_valid_o   (unit_req_valid_o),
    .unit_req_ready_i   (unit_req_ready_i),
    .unit_req_op_o      (unit_req_op_o),
    .unit_req_vd_o      (unit_req_vd_o),
    .unit_req_vs1_o     (unit_req_vs1_o),
    .unit_req_vsew_o    (unit_req_vsew_o),
    .unit_req_vlmul_o   (unit_req_vlmul_o),
    .unit_req_vl_o      (unit_req_vl_o),
    .unit_req_vstart_o  (unit_req_vstart_o),
    .unit_req_id_o      (unit_req_id_o),
    .unit_rsp_valid_i   (unit_rsp_valid_i),
    .unit_rsp_id_i      (unit_rsp_id_i)
  );

  vec_result vec_result_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb             (wb.result),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

endmodule

// File: logic/vec_decode.sv
`timescale 1ns/10ps

module vec_decode
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            issue_valid_i,
  output logic            issue_ready_o,
  input  elen_t           issue_instr_i,
  input  elen_t           issue_rs1_i,
  input  reg_idx_t        issue_rd_i,
  dec_op_if.decode        op
);

  insn_t insn;
  logic  opc_legal;
  logic  issue_hs;

  //////////////////////////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////////////////////////

  assign insn = insn_t'(issue_instr_i);

  assign opc_legal = insn.opcode inside {OP_VSETVL, OP_CSRR, OP_CSRW, OP_CSRS,
                                         OP_CSRC, OP_VADD, OP_VMUL};

  // Refill allowed in the pop cycle
  assign issue_ready_o = ~op.valid | op.pop;
  assign issue_hs      = issue_valid_i & issue_ready_o;

  //////////////////////////////////////////////////////////////////////
  // One-entry request buffer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      op.valid <= 1'b0;
    end else if (issue_hs) begin
      op.valid <= 1'b1;
    end else if (op.pop) begin
      op.valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (issue_hs) begin
      op.illegal  <= ~opc_legal;
      op.opcode   <= opcode_e'(insn.opcode);
      op.vsew     <= insn.vsew;
      op.vlmul    <= insn.vlmul;
      op.vd       <= insn.vd;
      op.vs1      <= insn.vs1;
      op.csr_addr <= insn.csr_addr;
      op.rs1      <= issue_rs1_i;
      op.rd       <= issue_rd_i;
    end
  end

  // Held operation must not change under the execute stage
  property p_buf_stable;
    @(posedge clk_i) disable iff (!rst_n_i)
      op.valid && !op.pop |=>
        $stable({op.illegal, op.opcode, op.vsew, op.vlmul, op.vd, op.vs1,
                 op.csr_addr, op.rs1, op.rd});
  endproperty

  a_buf_stable: assert property (p_buf_stable)
    else $error("decode buffer changed while held");

endmodule

// File: logic/vec_execute.sv
`timescale 1ns/10ps

module vec_execute
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  dec_op_if.execute op,
  wb_if.execute     wb,
  output logic      issue_resp_valid_o,
  output logic      issue_accept_o,
  output logic      busy_o,
  output logic      unit_req_valid_o,
  input  logic      unit_req_ready_i,
  output opcode_e   unit_req_op_o,
  output reg_idx_t  unit_req_vd_o,
  output reg_idx_t  unit_req_vs1_o,
  output vsew_e     unit_req_vsew_o,
  output vlmul_e    unit_req_vlmul_o,
  output vlen_t     unit_req_vl_o,
  output vlen_t     unit_req_vstart_o,
  output insn_id_t  unit_req_id_o,
  input  logic      unit_rsp_valid_i,
  input  insn_id_t  unit_rsp_id_i
);

  vlen_t              vstart_q, vstart_d;
  vlen_t              vl_q, vl_d;
  vtype_t             vtype_q, vtype_d;
  logic [NR_INSN-1:0] running_q, running_d;
  insn_id_t           next_id;
  logic               running_full;
  logic               is_vec, is_cfg, is_csr;
  logic               cfg_vill;
  vlen_t              vlmax;
  vlen_t              vl_new;
  elen_t              csr_rdata;
  logic               vec_pop;

  // Operation class
  always_comb begin
    is_vec = 1'b0;
    is_cfg = 1'b0;
    is_csr = 1'b0;
    case (op.opcode)
      OP_VSETVL:                         is_cfg = 1'b1;
      OP_CSRR, OP_CSRW, OP_CSRS, OP_CSRC: is_csr = 1'b1;
      OP_VADD, OP_VMUL:                  is_vec = 1'b1;
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration and CSRs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cfg_vill = (op.vsew > EW_32) || (op.vlmul inside {LMUL_RES, LMUL_F8});
    vlmax    = vlen_t'(VLENB) >> op.vsew;
    case (op.vlmul)
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_F4: vlmax = vlmax >> 2;
      default: ;
    endcase
    // All ones in rs1 asks for vlmax
    if (cfg_vill)                  vl_new = '0;
    else if (op.rs1 == '1)         vl_new = vlmax;
    else if (elen_t'(vlmax) < op.rs1) vl_new = vlmax;
    else                           vl_new = vlen_t'(op.rs1);
  end

  // Read data, unknown addresses give zero
  always_comb begin
    case (op.csr_addr)
      CSR_VSTART: csr_rdata = elen_t'(vstart_q);
      CSR_VL:     csr_rdata = elen_t'(vl_q);
      CSR_VTYPE:  csr_rdata = elen_t'(vtype_q);
      CSR_VLENB:  csr_rdata = elen_t'(VLENB);
      default:    csr_rdata = '0;
    endcase
  end

  always_comb begin
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    if (op.pop && !op.illegal) begin
      if (vec_pop) vstart_d = '0;
      if (is_cfg) begin
        vl_d    = vl_new;
        vtype_d = cfg_vill ? VTYPE_RESET
                           : '{vill: 1'b0, zero: '0, vsew: op.vsew, vlmul: op.vlmul};
      end
      if (is_csr && op.csr_addr == CSR_VSTART) begin
        case (op.opcode)
          OP_CSRW: vstart_d = vlen_t'(op.rs1);
          OP_CSRS: vstart_d = vstart_q | vlen_t'(op.rs1);
          OP_CSRC: vstart_d = vstart_q & ~vlen_t'(op.rs1);
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue and running set
  //////////////////////////////////////////////////////////////////////

  // Lowest free ID
  always_comb begin
    next_id = '0;
    for (int i = NR_INSN - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id = insn_id_t'(i);
    end
  end

  assign running_full = &running_q;

  assign unit_req_valid_o = op.valid & ~op.illegal & is_vec & ~vtype_q.vill & ~running_full;
  assign vec_pop          = unit_req_valid_o & unit_req_ready_i;

  // Illegal ops and rejected vector ops leave at once
  always_comb begin
    op.pop = 1'b0;
    if (op.valid) begin
      if (op.illegal)                 op.pop = 1'b1;
      else if (is_vec && vtype_q.vill) op.pop = 1'b1;
      else if (is_vec)                op.pop = vec_pop;
      else                            op.pop = wb.ready;
    end
  end

  assign issue_resp_valid_o = op.pop;
  assign issue_accept_o     = ~op.illegal & ~(is_vec & vtype_q.vill);

  always_comb begin
    running_d = running_q;
    if (vec_pop)          running_d[next_id] = 1'b1;
    if (unit_rsp_valid_i) running_d[unit_rsp_id_i] = 1'b0;
  end

  assign busy_o = |running_q;

  assign unit_req_op_o     = op.opcode;
  assign unit_req_vd_o     = op.vd;
  assign unit_req_vs1_o    = op.vs1;
  assign unit_req_vsew_o   = vtype_q.vsew;
  assign unit_req_vlmul_o  = vtype_q.vlmul;
  assign unit_req_vl_o     = vl_q;
  assign unit_req_vstart_o = vstart_q;
  assign unit_req_id_o     = next_id;

  // Config returns new vl, CSR ops return the old value
  assign wb.valid = op.valid & ~op.illegal & (is_cfg | is_csr);
  assign wb.rd    = op.rd;
  assign wb.data  = is_cfg ? elen_t'(vl_new) : csr_rdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vstart_q  <= '0;
      vl_q      <= '0;
      vtype_q   <= VTYPE_RESET;
      running_q <= '0;
    end else begin
      vstart_q  <= vstart_d;
      vl_q      <= vl_d;
      vtype_q   <= vtype_d;
      running_q <= running_d;
    end
  end

  // Unit only answers IDs it was given
  a_rsp_running: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unit_rsp_valid_i |-> running_q[unit_rsp_id_i])
    else $error("unit response for an idle ID");

  // A request never carries an ID still in flight, so never while full
  a_req_free_id: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unit_req_valid_o |-> !running_q[unit_req_id_o])
    else $error("unit request while ID busy");

endmodule

// File: logic/vec_isa_pkg.sv
package vec_isa_pkg;

  import vec_cfg_pkg::*;

  // Opcodes, all other codes are illegal
  typedef enum logic [3:0] {
    OP_VSETVL = 4'h1,
    OP_CSRR   = 4'h2,
    OP_CSRW   = 4'h3,
    OP_CSRS   = 4'h4,
    OP_CSRC   = 4'h5,
    OP_VADD   = 4'h8,
    OP_VMUL   = 4'h9
  } opcode_e;

  // Element width, codes 3 to 7 reserved
  typedef enum logic [2:0] {
    EW_8  = 3'd0,
    EW_16 = 3'd1,
    EW_32 = 3'd2
  } vsew_e;

  typedef enum logic [2:0] {
    LMUL_1   = 3'd0,
    LMUL_2   = 3'd1,
    LMUL_4   = 3'd2,
    LMUL_8   = 3'd3,
    LMUL_RES = 3'd4,
    LMUL_F8  = 3'd5,
    LMUL_F4  = 3'd6,
    LMUL_F2  = 3'd7
  } vlmul_e;

  typedef struct packed {
    logic        vill;
    logic [24:0] zero;
    vsew_e       vsew;
    vlmul_e      vlmul;
  } vtype_t;

  localparam vtype_t VTYPE_RESET = '{vill: 1'b1, zero: '0, vsew: EW_8, vlmul: LMUL_1};

  // Instruction word layout, msb first
  typedef struct packed {
    logic [3:0] opcode;
    vsew_e      vsew;
    vlmul_e     vlmul;
    reg_idx_t   vd;
    reg_idx_t   vs1;
    csr_addr_t  csr_addr;
  } insn_t;

endpackage

// File: logic/vec_result.sv
`timescale 1ns/10ps

module vec_result
  import vec_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  wb_if.result     wb,
  output logic     result_valid_o,
  input  logic     result_ready_i,
  output reg_idx_t result_rd_o,
  output elen_t    result_data_o
);

  logic load;

  // Free slot or draining this cycle
  assign wb.ready = ~result_valid_o | result_ready_i;
  assign load     = wb.valid & wb.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
    end else if (load) begin
      result_valid_o <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      result_rd_o   <= wb.rd;
      result_data_o <= wb.data;
    end
  end

  // Core sees a steady result until it takes it
  a_result_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o && !result_ready_i |=>
      result_valid_o && $stable({result_rd_o, result_data_o}))
    else $error("result changed under back-pressure");

endmodule

// File: logic/wb_if.sv
`timescale 1ns/10ps

interface wb_if
  import vec_cfg_pkg::*;
();

  logic     valid;
  logic     ready;
  reg_idx_t rd;
  elen_t    data;

  modport execute (
    output valid, rd, data,
    input  ready
  );

  modport result (
    input  valid, rd, data,
    output ready
  );

endinterface

// File: tb/vec_ctrl_model.svh
`ifndef VEC_CTRL_MODEL_SVH
`define VEC_CTRL_MODEL_SVH

// Reserved element widths and LMUL codes make vtype illegal
function automatic bit vtype_legal(input logic [2:0] sew, input logic [2:0] lmul);
  return (sew <= 3'd2) && (lmul != 3'd4) && (lmul != 3'd5);
endfunction

// Register group size in eighths of a register
function automatic int unsigned lmul_eighths(input logic [2:0] lmul);
  case (lmul)
    3'd0: return 8;
    3'd1: return 16;
    3'd2: return 32;
    3'd3: return 64;
    3'd6: return 2;
    3'd7: return 4;
    default: return 0;
  endcase
endfunction

function automatic int unsigned expect_vl(input logic [2:0] sew, input logic [2:0] lmul,
                                          input logic [31:0] rs1);
  int unsigned vlmax;
  if (!vtype_legal(sew, lmul)) return 0;
  vlmax = (VLEN * lmul_eighths(lmul)) / ((8 << sew) * 8);
  if (rs1 == 32'hFFFF_FFFF) return vlmax;
  return (rs1 < vlmax) ? rs1 : vlmax;
endfunction

function automatic logic [31:0] expect_vtype(input logic [2:0] sew, input logic [2:0] lmul);
  if (!vtype_legal(sew, lmul)) return 32'h8000_0000;
  return {26'd0, sew, lmul};
endfunction

function automatic logic [31:0] expect_csr(input logic [11:0] addr, input int unsigned vstart,
                                           input int unsigned vl, input logic [31:0] vtype);
  case (addr)
    12'h008: return vstart;
    12'hC20: return vl;
    12'hC21: return vtype;
    12'hC22: return VLENB;
    default: return 32'd0;
  endcase
endfunction

// Write, set and clear on the VL_W-bit vstart
function automatic int unsigned expect_vstart(input logic [3:0] opc, input logic [31:0] rs1,
                                              input int unsigned old);
  int unsigned mask;
  mask = (1 << VL_W) - 1;
  case (opc)
    4'h3: return rs1 & mask;
    4'h4: return (old | rs1) & mask;
    4'h5: return old & ~rs1 & mask;
    default: return old;
  endcase
endfunction

function automatic bit opcode_legal(input logic [3:0] opc);
  return opc inside {4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h8, 4'h9};
endfunction

function automatic bit is_vector_op(input logic [3:0] opc);
  return opc == 4'h8 || opc == 4'h9;
endfunction

function automatic bit expect_accept(input logic [3:0] opc, input logic vill);
  return opcode_legal(opc) && !(is_vector_op(opc) && vill);
endfunction

function automatic int lowest_free(input logic [NR_INSN-1:0] running);
  for (int i = 0; i < NR_INSN; i++) begin
    if (!running[i]) return i;
  end
  return -1;
endfunction

`endif

// File: tb/vec_ctrl_tb.sv
`timescale 1ns/10ps

module vec_ctrl_tb
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;
();

  `include "vec_ctrl_model.svh"

  localparam int CFG_N  = 30;
  localparam int DISP_N = 24;
  localparam int RAND_N = 120;
  localparam int N_INSTR = CFG_N * 3 + 11 + DISP_N + 11 + RAND_N;
  localparam int TIMEOUT_CYCLES = 16 + 200 * N_INSTR;

  logic clk_i;
  logic rst_n_i;
  logic issue_valid_i, issue_ready_o;
  elen_t issue_instr_i, issue_rs1_i;
  reg_idx_t issue_rd_i;
  logic issue_resp_valid_o, issue_accept_o, busy_o;
  logic unit_req_valid_o, unit_req_ready_i;
  opcode_e unit_req_op_o;
  reg_idx_t unit_req_vd_o, unit_req_vs1_o;
  vsew_e unit_req_vsew_o;
  vlmul_e unit_req_vlmul_o;
  vlen_t unit_req_vl_o, unit_req_vstart_o;
  insn_id_t unit_req_id_o;
  logic unit_rsp_valid_i;
  insn_id_t unit_rsp_id_i;
  logic result_valid_o, result_ready_i;
  reg_idx_t result_rd_o;
  elen_t result_data_o;

  // Model state and queues
  elen_t instr_q[$], rs1_q[$];
  reg_idx_t rd_q[$], exp_rd_q[$];
  elen_t exp_data_q[$];
  insn_id_t rsp_q[$];
  int unsigned m_vstart, m_vl;
  logic [31:0] m_vtype;
  logic [NR_INSN-1:0] m_running;
  logic req_held, res_held;
  logic [63:0] req_saved, res_saved;
  int err_count;
  int cycle_cnt;

  vec_ctrl_top vec_ctrl_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    err_count++;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic check_true(input bit cond, input string msg);
    assert (cond) else fail_run(msg);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Compare process, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare
    logic [31:0] w;
    logic [3:0] opc;
    logic req_hs;
    logic [63:0] req_bus;
    if (rst_n_i) begin
      req_hs = 1'b0;
      req_bus = {unit_req_op_o, unit_req_vd_o, unit_req_vs1_o, unit_req_vsew_o,
                 unit_req_vlmul_o, unit_req_vl_o, unit_req_vstart_o};
      check_val("busy_o", busy_o, m_running != 0);
      if (req_held) begin
        check_true(unit_req_valid_o, "unit request dropped while ready was low");
        check_val("unit_req_bus", req_bus, req_saved);
      end
      if (unit_req_valid_o) begin
        check_true(instr_q.size() > 0, "unit request with no buffered instruction");
        w = instr_q[0];
        check_true(is_vector_op(w[31:28]) && !m_vtype[31],
                   "unit request for an instruction that must not dispatch");
        check_true(m_running != '1, "unit request with all IDs outstanding");
        check_val("unit_req_op_o", unit_req_op_o, w[31:28]);
        check_val("unit_req_vd_o", unit_req_vd_o, w[21:17]);
        check_val("unit_req_vs1_o", unit_req_vs1_o, w[16:12]);
        check_val("unit_req_vsew_o", unit_req_vsew_o, m_vtype[5:3]);
        check_val("unit_req_vlmul_o", unit_req_vlmul_o, m_vtype[2:0]);
        check_val("unit_req_vl_o", unit_req_vl_o, m_vl);
        check_val("unit_req_vstart_o", unit_req_vstart_o, m_vstart);
        if (unit_req_ready_i) begin
          check_val("unit_req_id_o", unit_req_id_o, lowest_free(m_running));
          m_running[unit_req_id_o] = 1'b1;
          rsp_q.push_back(unit_req_id_o);
          req_hs = 1'b1;
        end
      end
      req_held = unit_req_valid_o & ~unit_req_ready_i;
      req_saved = req_bus;
      if (issue_resp_valid_o) begin
        check_true(instr_q.size() > 0, "issue response with no buffered instruction");
        w = instr_q.pop_front();
        opc = w[31:28];
        check_val("issue_accept_o", issue_accept_o, expect_accept(opc, m_vtype[31]));
        check_val("unit request count", req_hs,
                  is_vector_op(opc) && expect_accept(opc, m_vtype[31]));
        if (opc == 4'h1) begin
          exp_rd_q.push_back(rd_q[0]);
          exp_data_q.push_back(expect_vl(w[27:25], w[24:22], rs1_q[0]));
          m_vl = expect_vl(w[27:25], w[24:22], rs1_q[0]);
          m_vtype = expect_vtype(w[27:25], w[24:22]);
        end else if (opc inside {4'h2, 4'h3, 4'h4, 4'h5}) begin
          exp_rd_q.push_back(rd_q[0]);
          exp_data_q.push_back(expect_csr(w[11:0], m_vstart, m_vl, m_vtype));
          if (w[11:0] == CSR_VSTART) m_vstart = expect_vstart(opc, rs1_q[0], m_vstart);
        end else if (req_hs) begin
          m_vstart = 0;
        end
        void'(rs1_q.pop_front());
        void'(rd_q.pop_front());
      end else begin
        check_true(!req_hs, "unit request taken without an issue response");
      end
      if (res_held) begin
        check_true(result_valid_o, "result dropped while ready was low");
        check_val("result_bus", {result_rd_o, result_data_o}, res_saved);
      end
      if (result_valid_o && result_ready_i) begin
        check_true(exp_data_q.size() > 0, "result with no expected write-back");
        check_val("result_rd_o", result_rd_o, exp_rd_q.pop_front());
        check_val("result_data_o", result_data_o, exp_data_q.pop_front());
      end
      res_held = result_valid_o & ~result_ready_i;
      res_saved = {result_rd_o, result_data_o};
      if (unit_rsp_valid_i) m_running[unit_rsp_id_i] = 1'b0;
      // Buffer is free when empty or drained this cycle
      check_val("issue_ready_o", issue_ready_o, instr_q.size() == 0);
      if (issue_valid_i && issue_ready_o) begin
        instr_q.push_back(issue_instr_i);
        rs1_q.push_back(issue_rs1_i);
        rd_q.push_back(issue_rd_i);
      end
    end
  end

  // Execution unit with random stalls and late answers
  initial begin
    unit_req_ready_i = 1'b0;
    result_ready_i = 1'b0;
    unit_rsp_valid_i = 1'b0;
    unit_rsp_id_i = '0;
    @(posedge rst_n_i);
    forever begin
      @(posedge clk_i);
      #2;
      unit_req_ready_i = ($urandom % 4) != 0;
      result_ready_i = ($urandom % 2) != 0;
      unit_rsp_valid_i = 1'b0;
      if (rsp_q.size() > 0 && ($urandom % 6) == 0) begin
        unit_rsp_valid_i = 1'b1;
        unit_rsp_id_i = rsp_q.pop_front();
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles without finishing", cycle_cnt);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  function automatic elen_t make_instr(input logic [3:0] opc, input logic [2:0] sew,
                                       input logic [2:0] lmul, input logic [11:0] csr);
    return {opc, sew, lmul, 5'($urandom), 5'($urandom), csr};
  endfunction

  task automatic send(input elen_t instr, input elen_t rs1);
    bit taken;
    taken = 1'b0;
    issue_valid_i = 1'b1;
    issue_instr_i = instr;
    issue_rs1_i = rs1;
    issue_rd_i = 5'($urandom);
    while (!taken) begin
      @(negedge clk_i);
      taken = issue_ready_o;
    end
    @(posedge clk_i);
    #2;
    issue_valid_i = 1'b0;
  endtask

  task automatic send_cfg(input logic [2:0] sew, input logic [2:0] lmul);
    send(make_instr(4'h1, sew, lmul, 12'h0),
         ($urandom % 2) ? 32'hFFFF_FFFF : $urandom % 80);
  endtask

  task automatic wait_idle();
    while (instr_q.size() > 0 || exp_data_q.size() > 0 || m_running != 0) begin
      @(posedge clk_i);
    end
    #2;
  endtask

  initial begin
    logic [11:0] addrs[5];
    logic [3:0] bad_opc[9];
    int k;
    void'($urandom(8));
    addrs = '{12'h008, 12'hC20, 12'hC21, 12'hC22, 12'h123};
    bad_opc = '{4'h0, 4'h6, 4'h7, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
    err_count = 0;
    cycle_cnt = 0;
    m_vstart = 0;
    m_vl = 0;
    m_vtype = 32'h8000_0000;
    m_running = '0;
    req_held = 1'b0;
    res_held = 1'b0;
    rst_n_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    issue_rs1_i = '0;
    issue_rd_i = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    // Configuration with readback
    for (int i = 0; i < CFG_N; i++) begin
      send_cfg(3'($urandom), 3'($urandom));
      send(make_instr(4'h2, 3'd0, 3'd0, CSR_VTYPE), '0);
      send(make_instr(4'h2, 3'd0, 3'd0, CSR_VL), '0);
    end
    // CSR access and vstart reset
    send_cfg(3'd1, 3'd2);
    send(make_instr(4'h3, 3'd0, 3'd0, CSR_VSTART), $urandom % 512);
    send(make_instr(4'h4, 3'd0, 3'd0, CSR_VSTART), $urandom);
    send(make_instr(4'h5, 3'd0, 3'd0, CSR_VSTART), $urandom);
    for (int i = 0; i < 5; i++) send(make_instr(4'h2, 3'd0, 3'd0, addrs[i]), '0);
    send(make_instr(4'h8, 3'd0, 3'd0, 12'h0), '0);
    send(make_instr(4'h2, 3'd0, 3'd0, CSR_VSTART), '0);
    wait_idle();
    // Dispatch, rejection under vill and illegal opcodes
    for (int i = 0; i < DISP_N; i++) send(make_instr(4'h8 + 4'(i % 2), 3'd0, 3'd0, 12'h0), '0);
    send_cfg(3'd5, 3'd0);
    send(make_instr(4'h9, 3'd0, 3'd0, 12'h0), '0);
    for (int i = 0; i < 9; i++) send(make_instr(bad_opc[i], 3'($urandom), 3'd0, 12'h0), '0);
    wait_idle();
    // Random mix
    for (int i = 0; i < RAND_N; i++) begin
      k = $urandom % 10;
      if (k < 2) send_cfg(3'($urandom % 4), 3'($urandom));
      else if (k < 5) send(make_instr(4'(2 + $urandom % 4), 3'd0, 3'd0,
                                      addrs[$urandom % 5]), $urandom % 1024);
      else if (k < 9) send(make_instr(4'(8 + $urandom % 2), 3'd0, 3'd0, 12'h0), '0);
      else send(make_instr(bad_opc[$urandom % 9], 3'd0, 3'd0, 12'h0), '0);
    end
    wait_idle();
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: vec_ctrl.f
logic/vec_cfg_pkg.sv
logic/vec_isa_pkg.sv
logic/dec_op_if.sv
logic/wb_if.sv
logic/vec_decode.sv
logic/vec_execute.sv
logic/vec_result.sv
logic/vec_ctrl_top.sv
+incdir+tb
tb/vec_ctrl_tb.sv
